/* design/agen_pkg.sv */
// address generation package
// operand kinds, size codes, segment indices and the structs that
// carry an instruction into and out of the stage
package agen_pkg;

    localparam int NUM_REGS  = 8;
    localparam int SEG_SHIFT = 4;

    typedef enum logic [2:0] {
        kind_none      = 3'd0,
        kind_register  = 3'd1,
        kind_segment   = 3'd2,
        kind_mmx       = 3'd3,
        kind_modrm     = 3'd4,
        kind_immediate = 3'd5,
        kind_memory    = 3'd6,
        kind_system    = 3'd7
    } operand_kind_e;

    // unlisted codes read as zero
    typedef enum logic [2:0] {
        size_byte  = 3'd1,
        size_word  = 3'd2,
        size_dword = 3'd3,
        size_mmx   = 3'd5
    } op_size_e;

    typedef enum logic [2:0] {
        seg_es = 3'd0,
        seg_cs = 3'd1,
        seg_ss = 3'd2,
        seg_ds = 3'd3,
        seg_fs = 3'd4,
        seg_gs = 3'd5
    } seg_index_e;

    // gpr order is eax ecx edx ebx esp ebp esi edi
    typedef struct packed {
        logic [NUM_REGS-1:0][31:0] gpr;
        logic [5:0][15:0]          seg;
        logic [NUM_REGS-1:0][63:0] mmx;
    } reg_state_t;

    typedef struct packed {
        op_size_e      size;
        logic          set_d_flag;
        logic          clear_d_flag;
        operand_kind_e op0;
        operand_kind_e op1;
        logic [2:0]    op0_reg;
        logic [2:0]    op1_reg;
        logic [47:0]   imm;
        logic [3:0]    alu_op;
        logic [2:0]    flag_0;
        logic [2:0]    flag_1;
        logic [1:0]    stack_op;
        logic [31:0]   stack_address;
        seg_index_e    seg_override;
        logic          seg_override_valid;
        logic [31:0]   pc;
        logic          branch_taken;
        logic [15:0]   opcode;
    } agen_in_t;

    typedef struct packed {
        op_size_e    size;
        logic        set_d_flag;
        logic        clear_d_flag;
        logic [63:0] op0;
        logic [63:0] op1;
        logic [2:0]  op0_reg;
        logic [2:0]  op1_reg;
        logic        op0_is_reg;
        logic        op0_is_segment;
        logic        op0_is_mmx;
        logic        op1_is_address;
        logic [47:0] imm;
        logic [3:0]  alu_op;
        logic [2:0]  flag_0;
        logic [2:0]  flag_1;
        logic [1:0]  stack_op;
        logic [31:0] stack_address;
        logic [31:0] pc;
        logic        branch_taken;
        logic [15:0] opcode;
        logic        to_sys_controller;
    } agen_out_t;

    // one zero-extended view per register index
    typedef logic [NUM_REGS-1:0][63:0] gpr_view_t;

endpackage

/* design/reg_size_select.sv */
// register size selector
// builds the eight register views at the width picked by the operand size,
// shared by both operand selectors
module reg_size_select (
    input  agen_pkg::op_size_e   size,
    input  agen_pkg::reg_state_t regs,
    output agen_pkg::gpr_view_t  views
);
    import agen_pkg::*;

    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            case (size)
                size_byte: begin
                    // indices 4..7 map to ah ch dh bh
                    if (i < 4) begin
                        views[i] = {56'd0, regs.gpr[i][7:0]};
                    end else begin
                        views[i] = {56'd0, regs.gpr[i % 4][15:8]};
                    end
                end
                size_word: begin
                    views[i] = {48'd0, regs.gpr[i][15:0]};
                end
                size_dword: begin
                    views[i] = {32'd0, regs.gpr[i]};
                end
                size_mmx: begin
                    views[i] = regs.mmx[i];
                end
                default: begin
                    views[i] = '0;
                end
            endcase
        end
    end

endmodule

/* design/operand_select.sv */
// operand selector
// picks one 64-bit operand from its kind: register view, segment, mmx,
// immediate or string memory address
module operand_select #(
    // 0 for the destination (es:edi), 1 for the source (ds or override:esi)
    parameter bit IS_SOURCE = 1'b0
) (
    input  agen_pkg::operand_kind_e kind,
    input  logic [2:0]              reg_idx,
    input  logic [47:0]             imm,
    input  agen_pkg::seg_index_e    seg_override,
    input  logic                    seg_override_valid,
    input  agen_pkg::gpr_view_t     views,
    input  agen_pkg::reg_state_t    regs,
    output logic [63:0]             operand,
    output logic                    is_address
);
    import agen_pkg::*;

    localparam int ESI_IDX = 6;
    localparam int EDI_IDX = 7;

    logic [15:0] seg_value;
    logic [15:0] str_seg;
    logic [31:0] str_index;
    logic [31:0] str_addr;

    // codes 6 and 7 have no segment register behind them
    function automatic logic [15:0] seg_read(
        input reg_state_t state,
        input logic [2:0] idx
    );
        return (idx < 3'd6) ? state.seg[idx] : 16'd0;
    endfunction

    assign seg_value = seg_read(regs, reg_idx);

    // destination strings always go through es
    assign str_seg = !IS_SOURCE ? regs.seg[seg_es] :
                     seg_override_valid ? seg_read(regs, seg_override) :
                     regs.seg[seg_ds];

    assign str_index = IS_SOURCE ? regs.gpr[ESI_IDX] : regs.gpr[EDI_IDX];

    // real-mode style linear address, wraps at 32 bits
    assign str_addr = ({16'd0, str_seg} << SEG_SHIFT) + str_index;

    always_comb begin
        case (kind)
            kind_register: begin
                operand = views[reg_idx];
            end
            kind_segment: begin
                operand = {48'd0, seg_value};
            end
            kind_mmx: begin
                // full width whatever the size field says
                operand = regs.mmx[reg_idx];
            end
            kind_immediate: begin
                operand = {16'd0, imm};
            end
            kind_memory: begin
                operand = {32'd0, str_addr};
            end
            kind_none, kind_modrm, kind_system: begin
                operand = '0;
            end
            default: begin
                operand = '0;
            end
        endcase
    end

    // only the source side is read from memory later
    assign is_address = IS_SOURCE && (kind == kind_memory);

endmodule

/* design/agen_payload_build.sv */
// address generation payload builder
// forms op0 and op1, applies the stack pop override, derives the op0 flags
// and copies the pass-through fields toward the memory read stage
module agen_payload_build (
    input  agen_pkg::agen_in_t   instr,
    input  agen_pkg::reg_state_t regs,
    output agen_pkg::agen_out_t  payload
);
    import agen_pkg::*;

    gpr_view_t   views;
    logic [63:0] op0_value;
    logic [63:0] op1_value;
    logic        op1_is_addr;

    reg_size_select u_reg_size_select (
        .size  (instr.size),
        .regs  (regs),
        .views (views)
    );

    operand_select #(
        .IS_SOURCE(1'b0)
    ) u_op0_select (
        .kind               (instr.op0),
        .reg_idx            (instr.op0_reg),
        .imm                (instr.imm),
        .seg_override       (instr.seg_override),
        .seg_override_valid (instr.seg_override_valid),
        .views              (views),
        .regs               (regs),
        .operand            (op0_value),
        .is_address         ()
    );

    operand_select #(
        .IS_SOURCE(1'b1)
    ) u_op1_select (
        .kind               (instr.op1),
        .reg_idx            (instr.op1_reg),
        .imm                (instr.imm),
        .seg_override       (instr.seg_override),
        .seg_override_valid (instr.seg_override_valid),
        .views              (views),
        .regs               (regs),
        .operand            (op1_value),
        .is_address         (op1_is_addr)
    );

    always_comb begin
        payload.size              = instr.size;
        payload.set_d_flag        = instr.set_d_flag;
        payload.clear_d_flag      = instr.clear_d_flag;
        payload.op0               = op0_value;
        // pops read from the stack slot instead of the decoded source
        payload.op1               = instr.stack_op[1] ? {32'd0, instr.stack_address}
                                                      : op1_value;
        payload.op0_reg           = instr.op0_reg;
        payload.op1_reg           = instr.op1_reg;
        payload.op0_is_reg        = (instr.op0 == kind_register);
        payload.op0_is_segment    = (instr.op0 == kind_segment);
        payload.op0_is_mmx        = (instr.size == size_mmx);
        payload.op1_is_address    = op1_is_addr | instr.stack_op[1];
        payload.imm               = instr.imm;
        payload.alu_op            = instr.alu_op;
        payload.flag_0            = instr.flag_0;
        payload.flag_1            = instr.flag_1;
        payload.stack_op          = instr.stack_op;
        payload.stack_address     = instr.stack_address;
        payload.pc                = instr.pc;
        payload.branch_taken      = instr.branch_taken;
        payload.opcode            = instr.opcode;
        payload.to_sys_controller = (instr.op0 == kind_system);
    end

endmodule

/* design/pipe_stage.sv */
// one-entry valid/ready pipe register
// accepts when empty or when the consumer drains the current entry,
// flush drops whatever is held
module pipe_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                in_valid,
    output logic                in_ready,
    input  agen_pkg::agen_out_t in_data,
    output logic                out_valid,
    input  logic                out_ready,
    output agen_pkg::agen_out_t out_data
);
    import agen_pkg::*;

    logic      valid_q;
    agen_out_t data_q;

    assign in_ready = !valid_q || out_ready;

    // flush wins over an arriving transfer
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

/* design/address_generation_top.sv */
// address generation stage
// builds both operands from the decoded instruction and register snapshot
// and registers them toward the memory read stage
module address_generation_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 r_valid,
    output logic                 r_ready,
    input  agen_pkg::agen_in_t   r_instr,
    input  agen_pkg::reg_state_t r_regs,
    output logic                 a_valid,
    input  logic                 a_ready,
    output agen_pkg::agen_out_t  a_data
);
    import agen_pkg::*;

    agen_out_t payload;

    agen_payload_build u_payload_build (
        .instr   (r_instr),
        .regs    (r_regs),
        .payload (payload)
    );

    pipe_stage u_pipe_stage (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_data   (payload),
        .out_valid (a_valid),
        .out_ready (a_ready),
        .out_data  (a_data)
    );

endmodule

/* verification/agen_checker.sv */
// pipe stage checker
// reset and valid/ready handshake properties of the one-entry pipe register
module agen_checker (
    input logic                clk,
    input logic                reset,
    input logic                flush,
    input logic                in_valid,
    input logic                in_ready,
    input logic                out_valid,
    input logic                out_ready,
    input agen_pkg::agen_out_t out_data
);
    int unsigned fail_count = 0;

    // stage comes out of reset empty
    reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            $error("out_valid high right after reset");
            fail_count = fail_count + 1;
        end

    // a stalled entry holds until taken or flushed
    stall_holds_data: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_data)))
        else begin
            $error("output changed while stalled");
            fail_count = fail_count + 1;
        end

    accept_shows_valid: assert property (@(posedge clk) disable iff (reset)
        (in_valid && in_ready && !flush) |=> out_valid)
        else begin
            $error("accepted input did not show on out_valid");
            fail_count = fail_count + 1;
        end

endmodule

/* include/agen_tb_model.svh */
// address generation reference model
// expected stage output for one accepted instruction and register snapshot
`ifndef AGEN_TB_MODEL_SVH
`define AGEN_TB_MODEL_SVH

function automatic logic [63:0] agen_model_operand(
    input agen_pkg::agen_in_t   instr,
    input agen_pkg::reg_state_t regs,
    input bit                   src
);
    logic [2:0]  kind;
    logic [2:0]  idx;
    logic [2:0]  seg_sel;
    logic [31:0] addr;
    kind = src ? instr.op1 : instr.op0;
    idx = src ? instr.op1_reg : instr.op0_reg;
    seg_sel = !src ? 3'd0 : (instr.seg_override_valid ? instr.seg_override : 3'd3);
    addr = (seg_sel < 3'd6) ? {12'd0, regs.seg[seg_sel], 4'd0} : 32'd0;
    addr = addr + (src ? regs.gpr[6] : regs.gpr[7]);
    if (kind == 3'd1 && instr.size == 3'd1) begin
        return idx < 3'd4 ? {56'd0, regs.gpr[idx][7:0]} : {56'd0, regs.gpr[idx[1:0]][15:8]};
    end
    if (kind == 3'd1 && instr.size == 3'd2) return {48'd0, regs.gpr[idx][15:0]};
    if (kind == 3'd1 && instr.size == 3'd3) return {32'd0, regs.gpr[idx]};
    if (kind == 3'd1 && instr.size == 3'd5) return regs.mmx[idx];
    if (kind == 3'd2) return (idx < 3'd6) ? {48'd0, regs.seg[idx]} : 64'd0;
    if (kind == 3'd3) return regs.mmx[idx];
    if (kind == 3'd5) return {16'd0, instr.imm};
    if (kind == 3'd6) return {32'd0, addr};
    return 64'd0;
endfunction

function automatic agen_pkg::agen_out_t agen_model(
    input agen_pkg::agen_in_t   instr,
    input agen_pkg::reg_state_t regs
);
    agen_pkg::agen_out_t exp;
    exp = '{size: instr.size, set_d_flag: instr.set_d_flag, clear_d_flag: instr.clear_d_flag,
            op0_reg: instr.op0_reg, op1_reg: instr.op1_reg, imm: instr.imm,
            alu_op: instr.alu_op, flag_0: instr.flag_0, flag_1: instr.flag_1,
            stack_op: instr.stack_op, stack_address: instr.stack_address, pc: instr.pc,
            branch_taken: instr.branch_taken, opcode: instr.opcode, default: '0};
    exp.op0 = agen_model_operand(instr, regs, 1'b0);
    exp.op1 = agen_model_operand(instr, regs, 1'b1);
    exp.op1_is_address = (instr.op1 == 3'd6);
    if (instr.stack_op[1]) begin
        exp.op1 = {32'd0, instr.stack_address};
        exp.op1_is_address = 1'b1;
    end
    exp.op0_is_reg = (instr.op0 == 3'd1);
    exp.op0_is_segment = (instr.op0 == 3'd2);
    exp.op0_is_mmx = (instr.size == 3'd5);
    exp.to_sys_controller = (instr.op0 == 3'd7);
    return exp;
endfunction

`endif

/* verification/agen_tb.sv */
// address generation testbench
// random instructions and register snapshots against a reference model,
// with random back-pressure and flushes
module agen_tb;
    import agen_pkg::*;

    `include "agen_tb_model.svh"

    localparam int NUM_TRANSFERS = 2000;
    // cycle budget for the stimulus under random valid and ready
    localparam int STIM_CYCLES   = 3 * NUM_TRANSFERS;
    localparam int TIMEOUT       = 2 * STIM_CYCLES + 100;

    logic       clk;
    logic       reset;
    logic       flush;
    logic       r_valid;
    logic       r_ready;
    agen_in_t   r_instr;
    reg_state_t r_regs;
    logic       a_valid;
    logic       a_ready;
    agen_out_t  a_data;

    // expected payloads of items accepted and not yet delivered
    agen_out_t  exp_q[$];
    agen_out_t  expected;
    int         transfers = 0;
    int         cycles = 0;

    address_generation_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_instr (r_instr),
        .r_regs  (r_regs),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .a_data  (a_data)
    );

    bind pipe_stage agen_checker u_checker (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #2 clk = ~clk;

    task automatic check_payload(input string name, input agen_out_t exp, input agen_out_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "payload mismatch");
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s expected %b actual %b", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "handshake mismatch");
        end
    endtask

    task automatic drive_inputs();
        logic [191:0]                  instr_bits;
        logic [$bits(reg_state_t)-1:0] regs_bits;
        for (int i = 0; i < 192; i += 32) begin
            instr_bits[i +: 32] = $urandom;
        end
        for (int i = 0; i < $bits(reg_state_t); i += 32) begin
            regs_bits[i +: 32] = $urandom;
        end
        r_instr = instr_bits[$bits(agen_in_t)-1:0];
        r_regs = regs_bits;
        r_valid = ($urandom_range(0, 3) != 0);
        a_ready = ($urandom_range(0, 3) != 0);
        // roughly one cycle in twenty flushes
        flush = ($urandom_range(0, 99) < 5);
    endtask

    task automatic finish_run();
        // let the assertions of the last edge settle
        @(negedge clk);
        if (u_dut.u_pipe_stage.u_checker.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("pipe stage checker saw %0d assertion failures",
                     u_dut.u_pipe_stage.u_checker.fail_count);
            $display("TESTS FAILED");
            $fatal(1, "assertion failures");
        end
    endtask

    initial begin
        void'($urandom(29));
        clk = 1'b0;
        reset = 1'b1;
        flush = 1'b0;
        r_valid = 1'b0;
        a_ready = 1'b0;
        r_instr = '0;
        r_regs = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        forever begin
            drive_inputs();
            @(negedge clk);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("timeout after %0d cycles with %0d of %0d transfers seen",
                     cycles, transfers, NUM_TRANSFERS);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
        // assertion results of the previous edge
        if (u_dut.u_pipe_stage.u_checker.fail_count != 0) begin
            $display("pipe stage checker reported %0d assertion failures",
                     u_dut.u_pipe_stage.u_checker.fail_count);
            $display("TESTS FAILED");
            $fatal(1, "assertion failure");
        end
        if (reset) begin
            exp_q.delete();
        end else begin
            check_valid("a_valid", exp_q.size() != 0, a_valid);
            check_valid("r_ready", exp_q.size() == 0 || a_ready, r_ready);
            if (a_valid && a_ready) begin
                expected = exp_q.pop_front();
                check_payload($sformatf("a_data transfer %0d", transfers), expected, a_data);
                transfers = transfers + 1;
            end
            // held or arriving items are dropped by a flush
            if (flush) begin
                exp_q.delete();
            end else if (r_valid && r_ready) begin
                exp_q.push_back(agen_model(r_instr, r_regs));
            end
            if (transfers == NUM_TRANSFERS) begin
                finish_run();
            end
        end
    end

endmodule

/* build.f */
+incdir+include
design/agen_pkg.sv
design/reg_size_select.sv
design/operand_select.sv
design/agen_payload_build.sv
design/pipe_stage.sv
design/address_generation_top.sv
verification/agen_checker.sv
verification/agen_tb.sv

/* Bender.yml */
package:
  name: address_generation

sources:
  - include_dirs:
      - include
    files:
      - design/agen_pkg.sv
      - design/reg_size_select.sv
      - design/operand_select.sv
      - design/agen_payload_build.sv
      - design/pipe_stage.sv
      - design/address_generation_top.sv
      - verification/agen_checker.sv
      - verification/agen_tb.sv
